//--- design/armPkg.sv
// ARM subset package with word, register, flag and control types and encodings
package armPkg;

   typedef logic [31:0] wordT;      // Data or address word
   typedef logic [3:0]  regAddrT;   // Register number
   typedef logic [3:0]  condT;      // Condition field
   typedef logic [3:0]  flagsT;     // Ordered N, Z, C, V
   typedef logic [1:0]  aluCtrlT;
   typedef logic [1:0]  fwdSelT;
   typedef logic        immSrcT;

   // ALU operations
   localparam aluCtrlT AluAdd = 2'b00;
   localparam aluCtrlT AluSub = 2'b01;
   localparam aluCtrlT AluAnd = 2'b10;
   localparam aluCtrlT AluOrr = 2'b11;

   // Forward sources for the execute operands
   localparam fwdSelT FwdReg     = 2'b00;   // Value read in decode
   localparam fwdSelT FwdResultW = 2'b01;
   localparam fwdSelT FwdAluOutM = 2'b10;

   localparam immSrcT ImmSrc8  = 1'b0;   // Data-processing immediate
   localparam immSrcT ImmSrc12 = 1'b1;   // Load/store offset

   // Instruction fields
   localparam logic [1:0] OpDataProc = 2'b00;
   localparam logic [1:0] OpMemory   = 2'b01;

   localparam logic [3:0] FunctAdd = 4'b0100;
   localparam logic [3:0] FunctSub = 4'b0010;
   localparam logic [3:0] FunctAnd = 4'b0000;
   localparam logic [3:0] FunctOrr = 4'b1100;

   localparam condT CondAlways = 4'b1110;

   // R0 to R14 hold storage, R15 has none
   localparam int NumRegs = 15;

endpackage

//--- design/hazardIf.sv
// Hazard bundle linking data path and control to the forwarding and stall logic
`timescale 1ns/1ps

interface hazardIf;
   import armPkg::*;

   regAddrT raD1, raD2;       // Decode read addresses
   regAddrT raE1, raE2;       // Execute read addresses
   regAddrT waE, waM, waW;    // Destination per stage
   logic    regWriteM, regWriteW;
   logic    memToRegE;        // Load in execute
   fwdSelT  forwardA, forwardB;
   logic    stallF, stallD, flushE;

   modport datapath (output raD1, raD2, raE1, raE2, waE, waM, waW,
                     input  forwardA, forwardB, stallF, stallD);

   modport control (output regWriteM, regWriteW, memToRegE,
                    input  flushE);

   modport hazard (input  raD1, raD2, raE1, raE2, waE, waM, waW,
                   input  regWriteM, regWriteW, memToRegE,
                   output forwardA, forwardB, stallF, stallD, flushE);

endinterface

//--- design/arithLogicUnit.sv
// ALU for add, subtract, and, or with N, Z, C and V outputs
`timescale 1ns/1ps

module arithLogicUnit (
   input  armPkg::wordT    a,
   input  armPkg::wordT    b,
   input  armPkg::aluCtrlT aluCtrl,
   output armPkg::wordT    result,
   output armPkg::flagsT   flags
);
   import armPkg::*;

   logic        isSub, isArith;
   wordT        bOperand;
   logic [32:0] sum;
   logic        carry, overflow;

   assign isSub    = aluCtrl == AluSub;
   assign isArith  = aluCtrl == AluAdd || isSub;
   assign bOperand = isSub ? ~b : b;   // Subtract as a + ~b + 1
   assign sum      = {1'b0, a} + {1'b0, bOperand} + {32'b0, isSub};

   always_comb begin
      case (aluCtrl)
         AluAnd:  result = a & b;
         AluOrr:  result = a | b;
         default: result = sum[31:0];
      endcase
   end

   assign carry    = isArith & sum[32];   // No borrow on subtract
   assign overflow = isArith & ~(a[31] ^ bOperand[31]) & (a[31] ^ sum[31]);

   assign flags = {result[31], result == '0, carry, overflow};

endmodule

//--- design/hazardUnit.sv
// Hazard unit choosing forward sources and raising the load-use stall
`timescale 1ns/1ps

module hazardUnit (
   hazardIf.hazard hz
);
   import armPkg::*;

   logic loadUseStall;

   // Memory stage holds the newer value and wins over writeback
   function automatic fwdSelT pickSource(input regAddrT ra, input logic wrM, input regAddrT waM,
                                         input logic wrW, input regAddrT waW);
      if (wrM && waM == ra)
         return FwdAluOutM;
      else if (wrW && waW == ra)
         return FwdResultW;
      else
         return FwdReg;
   endfunction

   always_comb begin
      hz.forwardA = pickSource(hz.raE1, hz.regWriteM, hz.waM, hz.regWriteW, hz.waW);
      hz.forwardB = pickSource(hz.raE2, hz.regWriteM, hz.waM, hz.regWriteW, hz.waW);
   end

   // Load data only exists after the memory stage and needs one bubble
   assign loadUseStall = hz.memToRegE && (hz.waE == hz.raD1 || hz.waE == hz.raD2);

   assign hz.stallF = loadUseStall;
   assign hz.stallD = loadUseStall;
   assign hz.flushE = loadUseStall;

endmodule

//--- design/controlUnit.sv
// Control unit with instruction decode, control pipeline, condition check and flags
`timescale 1ns/1ps

module controlUnit (
   input  logic            clk,
   input  logic            reset,
   input  armPkg::wordT    instrD,
   input  armPkg::flagsT   aluFlagsE,
   hazardIf.control        hz,
   output armPkg::immSrcT  immSrcD,
   output logic            regSrcD,
   output logic            aluSrcE,
   output armPkg::aluCtrlT aluCtrlE,
   output logic            memWriteM,
   output logic            memToRegW,
   output logic            regWriteW
);
   import armPkg::*;

   aluCtrlT    dpCtrl;
   logic       dpKnown, dpArith;
   aluCtrlT    aluCtrlD;
   logic       aluSrcD, regWriteD, memWriteD, memToRegD;
   logic [1:0] flagWriteD, flagWriteE;   // [1] N and Z, [0] C and V
   logic       regWriteE, memWriteE, memToRegE;
   condT       condE;
   logic       condExE;
   flagsT      flags, flagsNext;
   logic       regWriteM, memToRegM;

   always_comb begin
      dpKnown = 1'b1;
      dpArith = 1'b0;
      case (instrD[24:21])
         FunctAdd: begin
            dpCtrl  = AluAdd;
            dpArith = 1'b1;
         end
         FunctSub: begin
            dpCtrl  = AluSub;
            dpArith = 1'b1;
         end
         FunctAnd: dpCtrl = AluAnd;
         FunctOrr: dpCtrl = AluOrr;
         default: begin
            dpCtrl  = AluAdd;
            dpKnown = 1'b0;   // Unsupported funct acts as a no-op
         end
      endcase
   end

   always_comb begin
      immSrcD    = ImmSrc8;
      regSrcD    = 1'b0;
      aluSrcD    = 1'b0;
      aluCtrlD   = AluAdd;   // Address add for loads and stores
      regWriteD  = 1'b0;
      memWriteD  = 1'b0;
      memToRegD  = 1'b0;
      flagWriteD = 2'b00;
      case (instrD[27:26])
         OpDataProc: begin
            aluSrcD    = instrD[25];   // I bit
            aluCtrlD   = dpCtrl;
            regWriteD  = dpKnown;
            flagWriteD = {instrD[20] & dpKnown, instrD[20] & dpArith};
         end
         OpMemory: begin
            immSrcD   = ImmSrc12;
            aluSrcD   = 1'b1;
            regSrcD   = ~instrD[20];   // STR reads Rd on port 2
            regWriteD = instrD[20];
            memToRegD = instrD[20];
            memWriteD = ~instrD[20];
         end
         default: ;
      endcase
   end

   // Execute register, flush turns the slot into a bubble
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         regWriteE  <= 1'b0;
         memWriteE  <= 1'b0;
         memToRegE  <= 1'b0;
         flagWriteE <= 2'b00;
         aluSrcE    <= 1'b0;
         aluCtrlE   <= AluAdd;
         condE      <= '0;
      end else begin
         regWriteE  <= regWriteD & ~hz.flushE;
         memWriteE  <= memWriteD & ~hz.flushE;
         memToRegE  <= memToRegD & ~hz.flushE;
         flagWriteE <= hz.flushE ? 2'b00 : flagWriteD;
         aluSrcE    <= aluSrcD;
         aluCtrlE   <= aluCtrlD;
         condE      <= instrD[31:28];
      end
   end

   always_comb begin
      case (condE)
         4'b0000:    condExE = flags[2];                          // EQ
         4'b0001:    condExE = ~flags[2];                         // NE
         4'b0010:    condExE = flags[1];                          // CS
         4'b0011:    condExE = ~flags[1];                         // CC
         4'b0100:    condExE = flags[3];                          // MI
         4'b0101:    condExE = ~flags[3];                         // PL
         4'b0110:    condExE = flags[0];                          // VS
         4'b0111:    condExE = ~flags[0];                         // VC
         4'b1000:    condExE = flags[1] & ~flags[2];              // HI
         4'b1001:    condExE = ~flags[1] | flags[2];              // LS
         4'b1010:    condExE = flags[3] == flags[0];              // GE
         4'b1011:    condExE = flags[3] != flags[0];              // LT
         4'b1100:    condExE = ~flags[2] & (flags[3] == flags[0]); // GT
         4'b1101:    condExE = flags[2] | (flags[3] != flags[0]);  // LE
         CondAlways: condExE = 1'b1;
         default:    condExE = 1'b0;
      endcase
   end

   assign flagsNext[3:2] = (flagWriteE[1] & condExE) ? aluFlagsE[3:2] : flags[3:2];
   assign flagsNext[1:0] = (flagWriteE[0] & condExE) ? aluFlagsE[1:0] : flags[1:0];

   // Flag register plus memory and writeback controls
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flags     <= '0;
         memWriteM <= 1'b0;
         regWriteM <= 1'b0;
         memToRegM <= 1'b0;
         regWriteW <= 1'b0;
         memToRegW <= 1'b0;
      end else begin
         flags     <= flagsNext;
         memWriteM <= memWriteE & condExE;
         regWriteM <= regWriteE & condExE;
         memToRegM <= memToRegE;
         regWriteW <= regWriteM;
         memToRegW <= memToRegM;
      end
   end

   assign hz.regWriteM = regWriteM;
   assign hz.regWriteW = regWriteW;
   assign hz.memToRegE = memToRegE;   // Ungated, a failed load still stalls

endmodule

//--- design/dataPath.sv
// Data path with PC, pipeline registers, register file, forwarding and result select
`timescale 1ns/1ps

module dataPath #(
   parameter armPkg::wordT ResetPc = '0
) (
   input  logic            clk,
   input  logic            reset,
   output armPkg::wordT    pcF,
   input  armPkg::wordT    instrF,
   output armPkg::wordT    instrD,
   input  logic            regSrcD,
   input  armPkg::immSrcT  immSrcD,
   input  logic            aluSrcE,
   input  armPkg::aluCtrlT aluCtrlE,
   input  logic            memToRegW,
   input  logic            regWriteW,
   output armPkg::flagsT   aluFlagsE,
   output armPkg::wordT    aluOutM,
   output armPkg::wordT    writeDataM,
   input  armPkg::wordT    readDataM,
   hazardIf.datapath       hz
);
   import armPkg::*;

   wordT regs [NumRegs];
   wordT rd1D, rd2D, extImmD;
   wordT rd1E, rd2E, extImmE;
   wordT srcAE, srcBE, writeDataE, aluResultE;
   wordT aluOutW, readDataW, resultW;

   function automatic wordT pickOperand(input fwdSelT sel, input wordT fromReg,
                                        input wordT fromW, input wordT fromM);
      case (sel)
         FwdResultW: return fromW;
         FwdAluOutM: return fromM;
         default:    return fromReg;
      endcase
   endfunction

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         pcF <= ResetPc;
      else if (!hz.stallF)
         pcF <= pcF + 32'd4;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         instrD <= '0;   // EQ condition, never passes on cleared flags
      else if (!hz.stallD)
         instrD <= instrF;
   end

   assign hz.raD1 = instrD[19:16];
   assign hz.raD2 = regSrcD ? instrD[15:12] : instrD[3:0];

   // Falling edge write, readable in decode the same cycle
   always_ff @(negedge clk) begin
      if (regWriteW && hz.waW < NumRegs)
         regs[hz.waW] <= resultW;
   end

   assign rd1D = (hz.raD1 < NumRegs) ? regs[hz.raD1] : '0;   // R15 reads as zero
   assign rd2D = (hz.raD2 < NumRegs) ? regs[hz.raD2] : '0;

   assign extImmD = (immSrcD == ImmSrc12) ? {20'b0, instrD[11:0]} : {24'b0, instrD[7:0]};

   // Register addresses through execute, memory and writeback
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         hz.raE1 <= '0;
         hz.raE2 <= '0;
         hz.waE  <= '0;
         hz.waM  <= '0;
         hz.waW  <= '0;
      end else begin
         hz.raE1 <= hz.raD1;
         hz.raE2 <= hz.raD2;
         hz.waE  <= instrD[15:12];
         hz.waM  <= hz.waE;
         hz.waW  <= hz.waM;
      end
   end

   // Operand and result words
   always_ff @(posedge clk) begin
      rd1E       <= rd1D;
      rd2E       <= rd2D;
      extImmE    <= extImmD;
      aluOutM    <= aluResultE;
      writeDataM <= writeDataE;
      aluOutW    <= aluOutM;
      readDataW  <= readDataM;
   end

   always_comb begin
      srcAE      = pickOperand(hz.forwardA, rd1E, resultW, aluOutM);
      writeDataE = pickOperand(hz.forwardB, rd2E, resultW, aluOutM);
   end

   assign srcBE = aluSrcE ? extImmE : writeDataE;

   arithLogicUnit uAlu (
      .a       (srcAE),
      .b       (srcBE),
      .aluCtrl (aluCtrlE),
      .result  (aluResultE),
      .flags   (aluFlagsE)
   );

   assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

//--- design/armPipelined.sv
// Five-stage pipelined ARM subset processor top level
`timescale 1ns/1ps

module armPipelined #(
   parameter armPkg::wordT ResetPc = '0
) (
   input  logic         clk,
   input  logic         reset,
   output armPkg::wordT pcF,
   input  armPkg::wordT instrF,
   output logic         memWriteM,
   output armPkg::wordT aluOutM,
   output armPkg::wordT writeDataM,
   input  armPkg::wordT readDataM
);
   import armPkg::*;

   wordT    instrD;
   flagsT   aluFlagsE;
   immSrcT  immSrcD;
   logic    regSrcD;
   logic    aluSrcE;
   aluCtrlT aluCtrlE;
   logic    memToRegW;
   logic    regWriteW;

   hazardIf hz ();

   controlUnit uCtrl (
      .clk       (clk),
      .reset     (reset),
      .instrD    (instrD),
      .aluFlagsE (aluFlagsE),
      .hz        (hz),
      .immSrcD   (immSrcD),
      .regSrcD   (regSrcD),
      .aluSrcE   (aluSrcE),
      .aluCtrlE  (aluCtrlE),
      .memWriteM (memWriteM),
      .memToRegW (memToRegW),
      .regWriteW (regWriteW)
   );

   dataPath #(.ResetPc(ResetPc)) uDataPath (
      .clk        (clk),
      .reset      (reset),
      .pcF        (pcF),
      .instrF     (instrF),
      .instrD     (instrD),
      .regSrcD    (regSrcD),
      .immSrcD    (immSrcD),
      .aluSrcE    (aluSrcE),
      .aluCtrlE   (aluCtrlE),
      .memToRegW  (memToRegW),
      .regWriteW  (regWriteW),
      .aluFlagsE  (aluFlagsE),
      .aluOutM    (aluOutM),
      .writeDataM (writeDataM),
      .readDataM  (readDataM),
      .hz         (hz)
   );

   hazardUnit uHazard (
      .hz (hz)
   );

endmodule

//--- verif/armPipelined_assertions.sv
// Hazard checks on the forward, stall and flush controls of the pipelined core
`timescale 1ns/1ps

module armPipelinedAssertions (
   input logic           clk,
   input logic           reset,
   input logic           stallF,
   input logic           stallD,
   input logic           flushE,
   input armPkg::fwdSelT forwardA
);

   // Fetch and decode always hold together
   stallPair: assert property (@(posedge clk) disable iff (reset) stallF == stallD)
      else $error("stallF and stallD differ");

   flushNeedsStall: assert property (@(posedge clk) disable iff (reset) flushE |-> stallD)
      else $error("flushE without stallD");

   fwdCodeUsed: assert property (@(posedge clk) disable iff (reset) forwardA != 2'b11)
      else $error("forwardA took the unused code");

   noFlushInReset: assert property (@(posedge clk) reset |-> !flushE)
      else $error("flushE raised during reset");

endmodule

// Hazard unit signals are reached through the interface instance in the core
bind armPipelined armPipelinedAssertions uHazardChecks (
   .clk      (clk),
   .reset    (reset),
   .stallF   (hz.stallF),
   .stallD   (hz.stallD),
   .flushE   (hz.flushE),
   .forwardA (hz.forwardA)
);

//--- verif/armPipelinedTb.sv
// Testbench running a random program on the pipelined ARM core against a reference model
`timescale 1ns/1ps

module armPipelinedTb;
   import armPkg::*;

   localparam wordT ResetPc   = 32'h0000_0040;
   localparam int   ImemWords = 512;
   localparam int   NumRandom = 200;
   localparam int   Timeout   = 2000;   // Cycles allowed for all stores
   localparam wordT FillInstr = {CondAlways, OpDataProc, 1'b0, FunctAnd, 1'b0, 20'd0};

   logic clk = 1'b0;
   logic reset;
   logic memWriteM;
   wordT pcF, instrF, aluOutM, writeDataM, readDataM;

   wordT imem [ImemWords];
   wordT dmem [64];
   wordT prog [$];
   wordT expIdx [$];
   wordT expData [$];
   wordT expPc [$];
   int   errors = 0;
   int   checks = 0;
   int   storesSeen = 0;
   int   numStores = 0;
   int   cyclesOut = 0;   // Cycles since reset release

   always #4 clk = ~clk;

   armPipelined #(.ResetPc(ResetPc)) DUT (
      .clk        (clk),
      .reset      (reset),
      .pcF        (pcF),
      .instrF     (instrF),
      .memWriteM  (memWriteM),
      .aluOutM    (aluOutM),
      .writeDataM (writeDataM),
      .readDataM  (readDataM)
   );

   assign instrF    = imem[(pcF - ResetPc) >> 2];
   assign readDataM = dmem[aluOutM[7:2]];

   task automatic checkEq(input string what, input wordT got, input wordT expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, expected);
      end
   endtask

   function automatic wordT fillData(input int idx);
      return (wordT'(idx) * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
   endfunction

   function automatic wordT dpInstr(input condT cond, input logic [3:0] funct, input logic imm,
                                    input logic s, input regAddrT rn, input regAddrT rd,
                                    input logic [7:0] op2);
      return {cond, OpDataProc, imm, funct, s, rn, rd, 4'b0000, op2};
   endfunction

   // Offset form with P and U set
   function automatic wordT memInstr(input condT cond, input logic load, input regAddrT rn,
                                     input regAddrT rd, input logic [11:0] offset);
      return {cond, OpMemory, 4'b0110, 1'b0, load, rn, rd, offset};
   endfunction

   function automatic wordT randomInstr();
      condT       cond;
      logic [3:0] funct;
      regAddrT    rn, rd, rm;
      cond = ($urandom_range(0, 1) == 0) ? CondAlways : condT'($urandom_range(0, 14));
      rn   = regAddrT'($urandom_range(0, 14));
      rd   = regAddrT'($urandom_range(0, 14));
      rm   = regAddrT'($urandom_range(0, 14));
      if ($urandom_range(0, 9) >= 7)
         return memInstr(cond, 1'($urandom), rn, rd, 12'($urandom));
      case ($urandom_range(0, 3))
         0:       funct = FunctAdd;
         1:       funct = FunctSub;
         2:       funct = FunctAnd;
         default: funct = FunctOrr;
      endcase
      if ($urandom_range(0, 1) == 1)
         return dpInstr(cond, funct, 1'b1, 1'($urandom), rn, rd, 8'($urandom));
      return dpInstr(cond, funct, 1'b0, 1'($urandom), rn, rd, {4'b0000, rm});
   endfunction

   function automatic wordT programWord(input int k);
      return (k < prog.size()) ? prog[k] : FillInstr;
   endfunction

   // ARM condition table on N, Z, C, V
   function automatic logic condHolds(input condT cond, input logic n, input logic z,
                                      input logic c, input logic v);
      case (cond)
         4'h0:    return z;
         4'h1:    return !z;
         4'h2:    return c;
         4'h3:    return !c;
         4'h4:    return n;
         4'h5:    return !n;
         4'h6:    return v;
         4'h7:    return !v;
         4'h8:    return c && !z;
         4'h9:    return !c || z;
         4'hA:    return n == v;
         4'hB:    return n != v;
         4'hC:    return !z && (n == v);
         4'hD:    return z || (n != v);
         default: return 1'b1;
      endcase
   endfunction

   // Load whose Rd the next instruction reads in decode through Rn, the Rm field or a store's Rd
   function automatic logic loadUse(input wordT older, input wordT newer);
      regAddrT second;
      second = (newer[27:26] == OpMemory && !newer[20]) ? newer[15:12] : newer[3:0];
      return older[27:26] == OpMemory && older[20] &&
             (older[15:12] == newer[19:16] || older[15:12] == second);
   endfunction

   task automatic buildProgram();
      for (int r = 0; r < NumRegs; r++)
         prog.push_back(dpInstr(CondAlways, FunctAnd, 1'b1, 1'b0, regAddrT'(r), regAddrT'(r),
                                8'd0));
      for (int r = 0; r < NumRegs; r++)
         prog.push_back(dpInstr(CondAlways, FunctOrr, 1'b1, 1'b0, regAddrT'(r), regAddrT'(r),
                                8'($urandom)));
      repeat (NumRandom) prog.push_back(randomInstr());
      for (int r = 0; r < NumRegs; r++)   // Epilogue dumps the register file
         prog.push_back(memInstr(CondAlways, 1'b0, 4'd0, regAddrT'(r), 12'(4 * r)));
   endtask

   task automatic runModel();
      wordT        regs [NumRegs];
      wordT        mem [64];
      logic        n, z, c, v;
      wordT        w, a, b, res, addr;
      logic [32:0] wide;
      for (int i = 0; i < 64; i++)
         mem[i] = fillData(i);
      {n, z, c, v} = 4'b0000;
      foreach (prog[k]) begin
         w = prog[k];
         a = regs[w[19:16]];
         if (condHolds(condT'(w[31:28]), n, z, c, v)) begin
            if (w[27:26] == OpMemory) begin
               addr = a + {20'b0, w[11:0]};
               if (w[20]) begin
                  regs[w[15:12]] = mem[addr[7:2]];
               end else begin
                  mem[addr[7:2]] = regs[w[15:12]];
                  expIdx.push_back(wordT'(addr[7:2]));
                  expData.push_back(regs[w[15:12]]);
               end
            end else begin
               b = w[25] ? {24'b0, w[7:0]} : regs[w[3:0]];
               case (w[24:21])
                  FunctAdd: begin
                     wide = {1'b0, a} + {1'b0, b};
                     res  = wide[31:0];
                     if (w[20]) begin
                        c = wide[32];
                        v = (a[31] == b[31]) && (res[31] != a[31]);
                     end
                  end
                  FunctSub: begin
                     res = a - b;
                     if (w[20]) begin
                        c = a >= b;   // No borrow
                        v = (a[31] != b[31]) && (res[31] != a[31]);
                     end
                  end
                  FunctAnd: res = a & b;
                  default:  res = a | b;
               endcase
               if (w[20]) begin
                  n = res[31];
                  z = res == '0;
               end
               regs[w[15:12]] = res;
            end
         end
      end
      numStores = expIdx.size();
   endtask

   // One repeated fetch address per load-use pair
   task automatic buildFetchOrder();
      for (int k = 0; k < prog.size() + 16; k++) begin
         expPc.push_back(ResetPc + wordT'(4 * k));
         if (k >= 2 && loadUse(programWord(k - 2), programWord(k - 1)))
            expPc.push_back(ResetPc + wordT'(4 * k));
      end
   endtask

   always @(negedge clk) begin
      if (reset) begin
         checkEq("pcF in reset", pcF, ResetPc);
         checkEq("memWriteM in reset", wordT'(memWriteM), '0);
      end else begin
         cyclesOut++;
         if (cyclesOut <= 3)
            checkEq("memWriteM after reset", wordT'(memWriteM), '0);
         if (expPc.size() != 0)
            checkEq("pcF", pcF, expPc.pop_front());
         if (memWriteM) begin
            storesSeen++;
            if (expIdx.size() == 0) begin
               errors++;
               $display("Store at time %0t to address %h was not expected", $time, aluOutM);
            end else begin
               checkEq("store index", wordT'(aluOutM[7:2]), expIdx.pop_front());
               checkEq("store data", writeDataM, expData.pop_front());
            end
            dmem[aluOutM[7:2]] = writeDataM;
         end
      end
   end

   initial begin
      int   seedVal;
      int   cycles;
      logic timedOut;
      reset   = 1'b1;
      seedVal = 32'h7136bc15;
      void'($urandom(seedVal));
      buildProgram();
      for (int i = 0; i < 64; i++)
         dmem[i] = fillData(i);
      for (int i = 0; i < ImemWords; i++)
         imem[i] = programWord(i);
      runModel();
      buildFetchOrder();
      repeat (8) @(posedge clk);
      #1 reset = 1'b0;
      cycles = 0;
      while (expIdx.size() != 0 && cycles < Timeout) begin
         @(posedge clk);
         cycles++;
      end
      timedOut = expIdx.size() != 0;
      if (timedOut) begin
         $display("Timeout after %0d cycles, %0d expected stores never appeared",
                  cycles, expIdx.size());
      end else begin
         repeat (4) @(posedge clk);   // Room for a stray store
         checkEq("store count", wordT'(storesSeen), wordT'(numStores));
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (!timedOut && errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

//--- armPipelined.f
design/armPkg.sv
design/hazardIf.sv
design/arithLogicUnit.sv
design/hazardUnit.sv
design/controlUnit.sv
design/dataPath.sv
design/armPipelined.sv
verif/armPipelined_assertions.sv
verif/armPipelinedTb.sv
